//--- Bender.yml
package:
  name: chipset_periph

sources:
  - files:
      - rtl/noc_pkg.sv
      - rtl/periph_pkg.sv
      - rtl/periph_if.sv
      - rtl/boot_rom.sv
      - rtl/clint_regs.sv
      - rtl/noc_req_deser.sv
      - rtl/periph_core.sv
      - rtl/noc_rsp_ser.sv
      - rtl/chipset_periph_top.sv
  - target: test
    files:
      - tb/tb_checker.sv
      - tb/tb_chipset_periph.sv

//--- flist.f
rtl/noc_pkg.sv
rtl/periph_pkg.sv
rtl/periph_if.sv
rtl/boot_rom.sv
rtl/clint_regs.sv
rtl/noc_req_deser.sv
rtl/periph_core.sv
rtl/noc_rsp_ser.sv
rtl/chipset_periph_top.sv
tb/tb_checker.sv
tb/tb_chipset_periph.sv

//--- rtl/boot_rom.hex
// one 64-bit word per line, word index 0 first
f1402573_00000297
02028293_30529073
00a00593_0105a023
10500073_ffdff06f
0000_0000_b007_0004
5a5a_a5a5_0123_4567
89ab_cdef_fedc_ba98
7654_3210_0f1e_2d3c
4b5a_6978_8796_a5b4
c3d2_e1f0_1357_9bdf
2468_ace0_dead_beef
cafe_f00d_8badf00d
1122_3344_5566_7788
99aa_bbcc_ddee_ff00
0f0f_f0f0_3c3c_c3c3
b007_c0de_0000_000f

//--- rtl/boot_rom.sv
////////////////////////////////////////////////////////////
// Boot rom table, filled from the hex image at elaboration.
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module boot_rom (
  input  logic                         clk_i,
  input  logic [periph_pkg::ROM_AW-1:0] addr_i,
  output logic [noc_pkg::FLIT_W-1:0]   rdata_o
);
  import noc_pkg::*;
  import periph_pkg::*;

  logic [FLIT_W-1:0] rom_mem [ROM_WORDS];
  logic [ROM_AW-1:0] addr_q;

  initial begin
    $readmemh(ROM_FILE, rom_mem);
  end

  always_ff @(posedge clk_i) begin
    addr_q <= addr_i;
  end

  // past the image the window reads as zero
  assign rdata_o = (addr_q < ROM_AW'(ROM_WORDS)) ? rom_mem[addr_q[ROM_IDX_W-1:0]] : '0;

endmodule

//--- rtl/chipset_periph_top.sv
////////////////////////////////////////////////////////////
// Peripheral block top, one NoC port to CLINT and boot rom.
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module chipset_periph_top (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       rtc_i,
  // NoC request side
  input  logic [noc_pkg::FLIT_W-1:0] noc_in_data_i,
  input  logic                       noc_in_valid_i,
  output logic                       noc_in_ready_o,
  // NoC response side
  output logic [noc_pkg::FLIT_W-1:0] noc_out_data_o,
  output logic                       noc_out_valid_o,
  input  logic                       noc_out_ready_i,
  // interrupts to the harts
  output periph_pkg::hart_vec_t      timer_irq_o,
  output periph_pkg::hart_vec_t      ipi_o
);

  periph_req_if req_if ();
  periph_rsp_if rsp_if ();

  noc_req_deser i_noc_req_deser (
    .clk_i          ( clk_i          ),
    .rst_n_i        ( rst_n_i        ),
    .noc_in_data_i  ( noc_in_data_i  ),
    .noc_in_valid_i ( noc_in_valid_i ),
    .noc_in_ready_o ( noc_in_ready_o ),
    .req            ( req_if.src     )
  );

  periph_core i_periph_core (
    .clk_i       ( clk_i       ),
    .rst_n_i     ( rst_n_i     ),
    .rtc_i       ( rtc_i       ),
    .req         ( req_if.dst  ),
    .rsp         ( rsp_if.src  ),
    .timer_irq_o ( timer_irq_o ),
    .ipi_o       ( ipi_o       )
  );

  noc_rsp_ser i_noc_rsp_ser (
    .clk_i           ( clk_i           ),
    .rst_n_i         ( rst_n_i         ),
    .rsp             ( rsp_if.dst      ),
    .noc_out_data_o  ( noc_out_data_o  ),
    .noc_out_valid_o ( noc_out_valid_o ),
    .noc_out_ready_i ( noc_out_ready_i )
  );

endmodule

//--- rtl/clint_regs.sv
////////////////////////////////////////////////////////////
// CLINT registers: msip, mtimecmp per hart and mtime, which
// counts synchronized rising edges of the rtc input.
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module clint_regs (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  input  logic                              rtc_i,
  input  logic                              we_i,
  input  logic                              re_i,
  input  logic [periph_pkg::CLINT_OFS_W-1:0] ofs_i,
  input  logic [noc_pkg::FLIT_W-1:0]        wdata_i,
  output logic [noc_pkg::FLIT_W-1:0]        rdata_o,
  output logic                              hit_o,
  output periph_pkg::hart_vec_t             timer_irq_o,
  output periph_pkg::hart_vec_t             ipi_o
);
  import noc_pkg::*;
  import periph_pkg::*;

  hart_vec_t         msip_q;
  hart_vec_t         irq_q;
  hart_vec_t         msip_hit;
  hart_vec_t         cmp_hit;
  logic              time_hit;
  logic [FLIT_W-1:0] mtimecmp_q [NUM_HARTS];
  logic [FLIT_W-1:0] mtime_q;
  // two sync stages plus one for the edge
  logic [2:0]        rtc_q;
  logic              rtc_rise;

  // offset decode
  always_comb begin
    for (int h = 0; h < NUM_HARTS; h++) begin
      msip_hit[h] = (ofs_i == MSIP_OFS + CLINT_OFS_W'(8 * h));
      cmp_hit[h]  = (ofs_i == MTIMECMP_OFS + CLINT_OFS_W'(8 * h));
    end
  end

  assign time_hit = (ofs_i == MTIME_OFS);
  assign hit_o    = (|msip_hit) | (|cmp_hit) | time_hit;

  always_comb begin
    rdata_o = '0;
    if (re_i) begin
      for (int h = 0; h < NUM_HARTS; h++) begin
        if (msip_hit[h]) begin
          rdata_o = {{(FLIT_W-1){1'b0}}, msip_q[h]};
        end
        if (cmp_hit[h]) begin
          rdata_o = mtimecmp_q[h];
        end
      end
      if (time_hit) begin
        rdata_o = mtime_q;
      end
    end
  end

  assign rtc_rise = rtc_q[1] & ~rtc_q[2];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rtc_q   <= '0;
      mtime_q <= '0;
      msip_q  <= '0;
      irq_q   <= '0;
      for (int h = 0; h < NUM_HARTS; h++) begin
        mtimecmp_q[h] <= '1;
      end
    end else begin
      rtc_q <= {rtc_q[1:0], rtc_i};
      // a software write wins over the tick
      if (we_i && time_hit) begin
        mtime_q <= wdata_i;
      end else if (rtc_rise) begin
        mtime_q <= mtime_q + 64'd1;
      end
      for (int h = 0; h < NUM_HARTS; h++) begin
        if (we_i && msip_hit[h]) begin
          msip_q[h] <= wdata_i[0];
        end
        if (we_i && cmp_hit[h]) begin
          mtimecmp_q[h] <= wdata_i;
        end
        irq_q[h] <= (mtime_q >= mtimecmp_q[h]);
      end
    end
  end

  assign timer_irq_o = irq_q;
  assign ipi_o       = msip_q;

endmodule

//--- rtl/noc_pkg.sv
////////////////////////////////////////////////////////////
// NoC flit format shared by the request and response sides.
// Import inside a module body where flits are decoded.
////////////////////////////////////////////////////////////

package noc_pkg;

  localparam int FLIT_W = 64;
  localparam int ADDR_W = 40;

  // requests come in on the input side, acks go out
  typedef enum logic [7:0] {
    LOAD_REQ  = 8'h01,
    STORE_REQ = 8'h02,
    LOAD_ACK  = 8'h11,
    STORE_ACK = 8'h12,
    ERR_ACK   = 8'h1f
  } noc_msg_e;

  // header flit, msb first
  typedef struct packed {
    noc_msg_e          msg_type;
    logic [7:0]        payload_len;
    logic [ADDR_W-1:0] addr;
    logic [7:0]        rsvd;
  } noc_hdr_t;

  // position in the packet decides which view applies
  typedef union packed {
    noc_hdr_t          hdr;
    logic [FLIT_W-1:0] data;
  } noc_flit_u;

endpackage

//--- rtl/noc_req_deser.sv
////////////////////////////////////////////////////////////
// Input side, gathers header and data flits into a request.
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module noc_req_deser (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic [noc_pkg::FLIT_W-1:0] noc_in_data_i,
  input  logic                       noc_in_valid_i,
  output logic                       noc_in_ready_o,
  periph_req_if.src                  req
);
  import noc_pkg::*;

  typedef enum logic [1:0] {S_HDR, S_DATA, S_HOLD} state_e;

  state_e            state_q;
  logic [7:0]        cnt_q;
  noc_flit_u         flit;
  logic              in_fire;
  logic              is_store;
  logic              is_req;
  logic [ADDR_W-1:0] addr_q;
  logic              write_q;
  logic              id_err_q;
  logic [FLIT_W-1:0] wdata_q;

  assign flit.data      = noc_in_data_i;
  assign noc_in_ready_o = (state_q != S_HOLD);
  assign in_fire        = noc_in_valid_i & noc_in_ready_o;
  assign is_store       = (flit.hdr.msg_type == STORE_REQ);
  assign is_req         = is_store | (flit.hdr.msg_type == LOAD_REQ);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= S_HDR;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        S_HDR: begin
          if (in_fire) begin
            if (is_store) begin
              state_q <= S_DATA;
              cnt_q   <= 8'd1;
            end else if (flit.hdr.payload_len == 8'd0) begin
              state_q <= S_HOLD;
            end else begin
              // drop the payload of anything else
              state_q <= S_DATA;
              cnt_q   <= flit.hdr.payload_len;
            end
          end
        end
        S_DATA: begin
          if (in_fire) begin
            cnt_q <= cnt_q - 8'd1;
            if (cnt_q == 8'd1) begin
              state_q <= S_HOLD;
            end
          end
        end
        S_HOLD: begin
          if (req.valid && req.ready) begin
            state_q <= S_HDR;
          end
        end
        default: state_q <= S_HDR;
      endcase
    end
  end

  // request payload
  always_ff @(posedge clk_i) begin
    if (in_fire && state_q == S_HDR) begin
      addr_q   <= flit.hdr.addr;
      write_q  <= is_store;
      id_err_q <= ~is_req;
    end
    if (in_fire && state_q == S_DATA) begin
      wdata_q <= flit.data;
    end
  end

  assign req.valid  = (state_q == S_HOLD);
  assign req.write  = write_q;
  assign req.addr   = addr_q;
  assign req.wdata  = wdata_q;
  assign req.id_err = id_err_q;

endmodule

//--- rtl/noc_rsp_ser.sv
////////////////////////////////////////////////////////////
// Output side, sends a header flit and for loads a data flit.
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module noc_rsp_ser (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  periph_rsp_if.dst                  rsp,
  output logic [noc_pkg::FLIT_W-1:0] noc_out_data_o,
  output logic                       noc_out_valid_o,
  input  logic                       noc_out_ready_i
);
  import noc_pkg::*;

  typedef enum logic [1:0] {S_IDLE, S_HDR, S_DATA} state_e;

  state_e            state_q;
  noc_flit_u         hdr_d;
  noc_flit_u         hdr_q;
  logic [FLIT_W-1:0] data_q;
  logic              rsp_fire;
  logic              out_fire;

  assign rsp.ready = (state_q == S_IDLE);
  assign rsp_fire  = rsp.valid & rsp.ready;
  assign out_fire  = noc_out_valid_o & noc_out_ready_i;

  // only a load ack carries data
  always_comb begin
    hdr_d.hdr.msg_type    = rsp.msg;
    hdr_d.hdr.payload_len = (rsp.msg == LOAD_ACK) ? 8'd1 : 8'd0;
    hdr_d.hdr.addr        = '0;
    hdr_d.hdr.rsvd        = '0;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= S_IDLE;
    end else begin
      case (state_q)
        S_IDLE: begin
          if (rsp_fire) begin
            state_q <= S_HDR;
          end
        end
        S_HDR: begin
          if (out_fire) begin
            state_q <= (hdr_q.hdr.payload_len != 8'd0) ? S_DATA : S_IDLE;
          end
        end
        S_DATA: begin
          if (out_fire) begin
            state_q <= S_IDLE;
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (rsp_fire) begin
      hdr_q  <= hdr_d;
      data_q <= rsp.rdata;
    end
  end

  assign noc_out_valid_o = (state_q != S_IDLE);
  assign noc_out_data_o  = (state_q == S_DATA) ? data_q : hdr_q.data;

endmodule

//--- rtl/periph_core.sv
////////////////////////////////////////////////////////////
// Address decode towards CLINT and boot rom, one response
// register. Takes a new request only when no response waits.
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module periph_core (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  rtc_i,
  periph_req_if.dst             req,
  periph_rsp_if.src             rsp,
  output periph_pkg::hart_vec_t timer_irq_o,
  output periph_pkg::hart_vec_t ipi_o
);
  import noc_pkg::*;
  import periph_pkg::*;

  logic              req_fire;
  logic              rom_win;
  logic              clint_win;
  logic              ofs_ok;
  logic              clint_hit;
  logic              clint_sel;
  logic              acc_ok;
  logic [ADDR_W-1:0] clint_ofs;
  logic [FLIT_W-1:0] clint_rdata;
  logic [FLIT_W-1:0] rom_rdata;
  logic [ROM_AW-1:0] rom_idx;
  logic [ROM_AW-1:0] rom_idx_q;
  logic              rsp_valid_q;
  noc_msg_e          msg_q;
  logic [FLIT_W-1:0] rdata_q;
  logic              rom_sel_q;

  assign req.ready = ~rsp_valid_q;
  assign req_fire  = req.valid & req.ready;

  ////////////////////////////////////////////////////////////
  // decode
  ////////////////////////////////////////////////////////////

  assign rom_win   = (req.addr >= ROM_BASE) && (req.addr < ROM_BASE + ROM_SIZE);
  assign clint_win = (req.addr >= CLINT_BASE) && (req.addr < CLINT_BASE + CLINT_SIZE);
  assign clint_ofs = req.addr - CLINT_BASE;
  // upper window offsets have no registers behind them
  assign ofs_ok    = (clint_ofs[ADDR_W-1:CLINT_OFS_W] == '0);
  assign clint_sel = clint_win & ofs_ok & ~req.id_err;

  assign acc_ok = ~req.id_err & ((rom_win & ~req.write) | (clint_sel & clint_hit));

  // rom address follows the request, then holds while the response waits
  assign rom_idx = req_fire ? req.addr[ROM_AW+2:3] : rom_idx_q;

  clint_regs i_clint_regs (
    .clk_i       ( clk_i                          ),
    .rst_n_i     ( rst_n_i                        ),
    .rtc_i       ( rtc_i                          ),
    .we_i        ( req_fire & clint_sel & req.write  ),
    .re_i        ( req_fire & clint_sel & ~req.write ),
    .ofs_i       ( clint_ofs[CLINT_OFS_W-1:0]     ),
    .wdata_i     ( req.wdata                      ),
    .rdata_o     ( clint_rdata                    ),
    .hit_o       ( clint_hit                      ),
    .timer_irq_o ( timer_irq_o                    ),
    .ipi_o       ( ipi_o                          )
  );

  boot_rom i_boot_rom (
    .clk_i   ( clk_i     ),
    .addr_i  ( rom_idx   ),
    .rdata_o ( rom_rdata )
  );

  ////////////////////////////////////////////////////////////
  // response register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rsp_valid_q <= 1'b0;
    end else if (req_fire) begin
      rsp_valid_q <= 1'b1;
    end else if (rsp.valid && rsp.ready) begin
      rsp_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      rom_idx_q <= rom_idx;
      rdata_q   <= clint_rdata;
      rom_sel_q <= rom_win;
      if (!acc_ok) begin
        msg_q <= ERR_ACK;
      end else if (req.write) begin
        msg_q <= STORE_ACK;
      end else begin
        msg_q <= LOAD_ACK;
      end
    end
  end

  assign rsp.valid = rsp_valid_q;
  assign rsp.msg   = msg_q;
  assign rsp.rdata = rom_sel_q ? rom_rdata : rdata_q;

endmodule

//--- rtl/periph_if.sv
////////////////////////////////////////////////////////////
// Request and response channels inside the block.
// Valid/ready, payload held stable until the transfer.
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

interface periph_req_if;
  import noc_pkg::*;

  logic              valid;
  logic              ready;
  logic              write;
  logic [ADDR_W-1:0] addr;
  logic [FLIT_W-1:0] wdata;
  // header type was not a request
  logic              id_err;

  modport src (output valid, write, addr, wdata, id_err, input ready);
  modport dst (input valid, write, addr, wdata, id_err, output ready);

endinterface

interface periph_rsp_if;
  import noc_pkg::*;

  logic              valid;
  logic              ready;
  noc_msg_e          msg;
  logic [FLIT_W-1:0] rdata;

  modport src (output valid, msg, rdata, input ready);
  modport dst (input valid, msg, rdata, output ready);

endinterface

//--- rtl/periph_pkg.sv
////////////////////////////////////////////////////////////
// Address map and CLINT layout of the peripheral block.
////////////////////////////////////////////////////////////

package periph_pkg;

  localparam int NUM_HARTS = 2;

  // boot rom window
  localparam logic [noc_pkg::ADDR_W-1:0] ROM_BASE = 40'h90_0001_0000;
  localparam logic [noc_pkg::ADDR_W-1:0] ROM_SIZE = 40'h00_0001_0000;
  localparam int ROM_WORDS = 16;
  localparam int ROM_IDX_W = $clog2(ROM_WORDS);
  // word index over the whole window
  localparam int ROM_AW    = $clog2(ROM_SIZE / 8);
  localparam string ROM_FILE = "rtl/boot_rom.hex";

  // clint window
  localparam logic [noc_pkg::ADDR_W-1:0] CLINT_BASE = 40'h90_0200_0000;
  localparam logic [noc_pkg::ADDR_W-1:0] CLINT_SIZE = 40'h00_0100_0000;
  localparam int CLINT_OFS_W = 16;

  // register offsets, per-hart registers at 8 byte steps
  localparam logic [CLINT_OFS_W-1:0] MSIP_OFS     = 16'h0000;
  localparam logic [CLINT_OFS_W-1:0] MTIMECMP_OFS = 16'h4000;
  localparam logic [CLINT_OFS_W-1:0] MTIME_OFS    = 16'hbff8;

  typedef logic [NUM_HARTS-1:0] hart_vec_t;

endpackage

//--- tb/tb_checker.sv
////////////////////////////////////////////////////////////
// Response and interrupt checker, fed with expected values
// by the testbench before each request is sent.
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module tb_checker (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic [noc_pkg::FLIT_W-1:0] noc_in_data_i,
  input  logic                       noc_in_valid_i,
  input  logic                       noc_in_ready_i,
  input  logic [noc_pkg::FLIT_W-1:0] noc_out_data_i,
  input  logic                       noc_out_valid_i,
  input  logic                       noc_out_ready_i,
  input  periph_pkg::hart_vec_t      timer_irq_i,
  input  periph_pkg::hart_vec_t      ipi_i,
  input  logic                       exp_push_i,
  input  logic [7:0]                 exp_msg_i,
  input  logic [noc_pkg::FLIT_W-1:0] exp_data_i,
  input  logic                       irq_check_i,
  input  periph_pkg::hart_vec_t      exp_irq_i,
  input  periph_pkg::hart_vec_t      exp_ipi_i,
  output int                         err_cnt_o,
  output int                         chk_cnt_o,
  output int                         rsp_cnt_o
);
  import noc_pkg::*;

  // {msg, data} per outstanding request
  logic [71:0] exp_q [$];
  logic [71:0] cur;
  logic [63:0] exp_hdr;
  logic        in_data;
  noc_hdr_t    in_hdr;
  // request flits still to come after the header
  logic [7:0]  in_left;
  // last request flit taken on the previous edge
  logic        hold_exp;

  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      exp_q.delete();
      in_data   = 1'b0;
      in_left   = '0;
      hold_exp  = 1'b0;
      err_cnt_o = 0;
      chk_cnt_o = 0;
      rsp_cnt_o = 0;
    end else begin
      if (exp_push_i) begin
        exp_q.push_back({exp_msg_i, exp_data_i});
      end
      // a complete request holds the input side for at least a cycle
      if (hold_exp) begin
        chk_cnt_o++;
        if (noc_in_ready_i !== 1'b0) begin
          $display("ERROR noc_in_ready_o: expected %h, got %h", 1'b0, noc_in_ready_i);
          err_cnt_o++;
        end
      end
      hold_exp = 1'b0;
      if (noc_in_valid_i && noc_in_ready_i) begin
        if (in_left != 8'd0) begin
          in_left--;
          hold_exp = (in_left == 8'd0);
        end else begin
          in_hdr = noc_in_data_i;
          // a store takes one data flit, other types their payload length
          in_left  = (in_hdr.msg_type == STORE_REQ) ? 8'd1 : in_hdr.payload_len;
          hold_exp = (in_left == 8'd0);
        end
      end
      if (noc_out_valid_i && noc_out_ready_i) begin
        if (in_data) begin
          chk_cnt_o++;
          if (noc_out_data_i !== cur[63:0]) begin
            $display("ERROR noc_out_data_o data flit: expected %h, got %h",
                     cur[63:0], noc_out_data_i);
            err_cnt_o++;
          end
          in_data = 1'b0;
          rsp_cnt_o++;
        end else if (exp_q.size() == 0) begin
          $display("response flit %h arrived with no request outstanding", noc_out_data_i);
          err_cnt_o++;
        end else begin
          cur = exp_q.pop_front();
          // ack header carries no address, length 1 only for a load
          exp_hdr = {cur[71:64], (cur[71:64] == LOAD_ACK) ? 8'd1 : 8'd0, 40'h0, 8'h0};
          chk_cnt_o++;
          if (noc_out_data_i !== exp_hdr) begin
            $display("ERROR noc_out_data_o header flit: expected %h, got %h",
                     exp_hdr, noc_out_data_i);
            err_cnt_o++;
          end
          if (cur[71:64] == LOAD_ACK) begin
            in_data = 1'b1;
          end else begin
            rsp_cnt_o++;
          end
        end
      end
      if (irq_check_i) begin
        chk_cnt_o += 2;
        if (timer_irq_i !== exp_irq_i) begin
          $display("ERROR timer_irq_o: expected %h, got %h", exp_irq_i, timer_irq_i);
          err_cnt_o++;
        end
        if (ipi_i !== exp_ipi_i) begin
          $display("ERROR ipi_o: expected %h, got %h", exp_ipi_i, ipi_i);
          err_cnt_o++;
        end
      end
    end
  end

endmodule

//--- tb/tb_chipset_periph.sv
////////////////////////////////////////////////////////////
// Testbench for the peripheral block, runs a request table
// through the NoC port under random output back-pressure.
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module tb_chipset_periph;
  import noc_pkg::*;
  import periph_pkg::*;

  localparam int TMO_CYC = 200;

  // one row of the stimulus table
  typedef struct packed {
    logic [7:0]  msg;
    logic [39:0] addr;
    logic [63:0] wdata;
    logic [3:0]  rtc_n;
    logic [7:0]  exp_msg;
    logic [63:0] exp_data;
    logic        chk_irq;
    logic [1:0]  exp_irq;
    logic [1:0]  exp_ipi;
  } stim_t;

  logic        clk_i;
  logic        rst_n_i;
  logic        rtc_i;
  logic [63:0] noc_in_data_i;
  logic        noc_in_valid_i;
  logic        noc_in_ready_o;
  logic [63:0] noc_out_data_o;
  logic        noc_out_valid_o;
  logic        noc_out_ready_i;
  hart_vec_t   timer_irq_o;
  hart_vec_t   ipi_o;

  logic        exp_push;
  logic [7:0]  exp_msg;
  logic [63:0] exp_data;
  logic        irq_check;
  hart_vec_t   exp_irq;
  hart_vec_t   exp_ipi;
  int          err_cnt;
  int          chk_cnt;
  int          rsp_cnt;
  int          tmo_cnt;
  int          i;
  logic [31:0] rng;
  logic [63:0] rom_ref [16];
  stim_t       stim_q [$];

  chipset_periph_top uut (
    .clk_i           ( clk_i           ),
    .rst_n_i         ( rst_n_i         ),
    .rtc_i           ( rtc_i           ),
    .noc_in_data_i   ( noc_in_data_i   ),
    .noc_in_valid_i  ( noc_in_valid_i  ),
    .noc_in_ready_o  ( noc_in_ready_o  ),
    .noc_out_data_o  ( noc_out_data_o  ),
    .noc_out_valid_o ( noc_out_valid_o ),
    .noc_out_ready_i ( noc_out_ready_i ),
    .timer_irq_o     ( timer_irq_o     ),
    .ipi_o           ( ipi_o           )
  );

  tb_checker i_tb_checker (
    .clk_i           ( clk_i           ),
    .rst_n_i         ( rst_n_i         ),
    .noc_in_data_i   ( noc_in_data_i   ),
    .noc_in_valid_i  ( noc_in_valid_i  ),
    .noc_in_ready_i  ( noc_in_ready_o  ),
    .noc_out_data_i  ( noc_out_data_o  ),
    .noc_out_valid_i ( noc_out_valid_o ),
    .noc_out_ready_i ( noc_out_ready_i ),
    .timer_irq_i     ( timer_irq_o     ),
    .ipi_i           ( ipi_o           ),
    .exp_push_i      ( exp_push        ),
    .exp_msg_i       ( exp_msg         ),
    .exp_data_i      ( exp_data        ),
    .irq_check_i     ( irq_check       ),
    .exp_irq_i       ( exp_irq         ),
    .exp_ipi_i       ( exp_ipi         ),
    .err_cnt_o       ( err_cnt         ),
    .chk_cnt_o       ( chk_cnt         ),
    .rsp_cnt_o       ( rsp_cnt         )
  );

  always #20 clk_i = ~clk_i;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  // output ready low on about one cycle in four
  always begin
    @(posedge clk_i);
    #2;
    rng = xorshift32(rng);
    noc_out_ready_i = (rng[1:0] != 2'b00);
  end

  function automatic logic [63:0] rom_word(input int idx);
    return (idx < 16) ? rom_ref[idx] : 64'h0;
  endfunction

  task automatic add_entry(input logic [7:0] msg, input logic [39:0] addr,
                           input logic [63:0] wdata, input int rtc_n,
                           input logic [7:0] emsg, input logic [63:0] edata,
                           input logic chk, input logic [1:0] irq, input logic [1:0] ipi);
    stim_t e;
    e = '{msg, addr, wdata, 4'(rtc_n), emsg, edata, chk, irq, ipi};
    stim_q.push_back(e);
  endtask

  ////////////////////////////////////////////////////////////
  // stimulus table
  ////////////////////////////////////////////////////////////

  task automatic build_table();
    // rom loads, inside and past the image
    add_entry(LOAD_REQ, ROM_BASE, '0, 0, LOAD_ACK, rom_word(0), 0, 2'b00, 2'b00);
    add_entry(LOAD_REQ, ROM_BASE + 40'h28, '0, 0, LOAD_ACK, rom_word(5), 0, 2'b00, 2'b00);
    add_entry(LOAD_REQ, ROM_BASE + 40'h78, '0, 0, LOAD_ACK, rom_word(15), 0, 2'b00, 2'b00);
    add_entry(LOAD_REQ, ROM_BASE + 40'h80, '0, 0, LOAD_ACK, 64'h0, 0, 2'b00, 2'b00);
    add_entry(LOAD_REQ, ROM_BASE + 40'h1000, '0, 0, LOAD_ACK, 64'h0, 0, 2'b00, 2'b00);
    // msip of hart 1
    add_entry(STORE_REQ, CLINT_BASE + 40'h8, 64'h1, 0, STORE_ACK, '0, 1, 2'b00, 2'b10);
    add_entry(LOAD_REQ, CLINT_BASE + 40'h8, '0, 0, LOAD_ACK, 64'h1, 0, 2'b00, 2'b00);
    add_entry(STORE_REQ, CLINT_BASE + 40'h8, 64'h0, 0, STORE_ACK, '0, 1, 2'b00, 2'b00);
    // mtime ticked away from zero and cleared, then five rtc ticks
    add_entry(STORE_REQ, CLINT_BASE + 40'hbff8, 64'h0, 3, STORE_ACK, '0, 0, 2'b00, 2'b00);
    add_entry(LOAD_REQ, CLINT_BASE + 40'hbff8, '0, 5, LOAD_ACK, 64'h5, 0, 2'b00, 2'b00);
    // mtimecmp of hart 0 below mtime, then back to all ones
    add_entry(STORE_REQ, CLINT_BASE + 40'h4000, 64'h2, 0, STORE_ACK, '0, 1, 2'b01, 2'b00);
    add_entry(STORE_REQ, CLINT_BASE + 40'h4000, '1, 0, STORE_ACK, '0, 1, 2'b00, 2'b00);
    // error cases, then a normal load again
    add_entry(LOAD_REQ, 40'h80_0000_0000, '0, 0, ERR_ACK, '0, 0, 2'b00, 2'b00);
    add_entry(LOAD_REQ, CLINT_BASE + 40'h10, '0, 0, ERR_ACK, '0, 0, 2'b00, 2'b00);
    add_entry(STORE_REQ, ROM_BASE, 64'h1234, 0, ERR_ACK, '0, 0, 2'b00, 2'b00);
    add_entry(LOAD_ACK, ROM_BASE, 64'hdead, 0, ERR_ACK, '0, 0, 2'b00, 2'b00);
    add_entry(LOAD_REQ, ROM_BASE + 40'h18, '0, 0, LOAD_ACK, rom_word(3), 0, 2'b00, 2'b00);
  endtask

  ////////////////////////////////////////////////////////////
  // driver tasks
  ////////////////////////////////////////////////////////////

  task automatic send_flit(input logic [63:0] f);
    int n;
    n = 0;
    noc_in_data_i  = f;
    noc_in_valid_i = 1'b1;
    while (!noc_in_ready_o && n < TMO_CYC) begin
      @(posedge clk_i);
      #2;
      n++;
    end
    if (!noc_in_ready_o) begin
      $display("timeout: noc_in_ready_o never came up to take a request flit");
      tmo_cnt++;
    end else begin
      @(posedge clk_i);
      #2;
    end
    noc_in_valid_i = 1'b0;
  endtask

  task automatic wait_rsp(input int target);
    int n;
    n = 0;
    while (rsp_cnt < target && n < TMO_CYC) begin
      @(posedge clk_i);
      #2;
      n++;
    end
    if (rsp_cnt < target) begin
      $display("timeout: response %0d was not completed on the NoC output", target);
      tmo_cnt++;
    end
  endtask

  task automatic pulse_rtc();
    rtc_i = 1'b1;
    repeat (3) @(posedge clk_i);
    #2;
    rtc_i = 1'b0;
    repeat (3) @(posedge clk_i);
    #2;
  endtask

  task automatic apply_entry(input stim_t e, input int target);
    // non-load headers carry one flit after them
    logic [7:0] len;
    len = (e.msg == LOAD_REQ) ? 8'd0 : 8'd1;
    repeat (e.rtc_n) pulse_rtc();
    if (e.rtc_n != 0) begin
      repeat (6) @(posedge clk_i);
      #2;
    end
    exp_msg  = e.exp_msg;
    exp_data = e.exp_data;
    exp_push = 1'b1;
    @(posedge clk_i);
    #2;
    exp_push = 1'b0;
    send_flit({e.msg, len, e.addr, 8'h00});
    if (len != 0 && tmo_cnt == 0) begin
      send_flit(e.wdata);
    end
    if (tmo_cnt == 0) begin
      wait_rsp(target);
    end
    if (e.chk_irq && tmo_cnt == 0) begin
      exp_irq   = e.exp_irq;
      exp_ipi   = e.exp_ipi;
      irq_check = 1'b1;
      @(posedge clk_i);
      #2;
      irq_check = 1'b0;
    end
  endtask

  initial begin
    clk_i           = 1'b0;
    rst_n_i         = 1'b0;
    rtc_i           = 1'b0;
    noc_in_data_i   = '0;
    noc_in_valid_i  = 1'b0;
    noc_out_ready_i = 1'b1;
    exp_push        = 1'b0;
    exp_msg         = '0;
    exp_data        = '0;
    irq_check       = 1'b0;
    exp_irq         = '0;
    exp_ipi         = '0;
    tmo_cnt         = 0;
    rng             = 32'd52178;
    $readmemh("rtl/boot_rom.hex", rom_ref);
    build_table();
    repeat (5) @(posedge clk_i);
    #2;
    rst_n_i = 1'b1;
    for (i = 0; i < stim_q.size() && tmo_cnt == 0; i++) begin
      apply_entry(stim_q[i], i + 1);
    end
    // idle time so a stray extra flit still reaches the checker
    repeat (10) @(posedge clk_i);
    #2;
    $display("errors %0d, checks %0d, responses %0d of %0d, timeouts %0d",
             err_cnt, chk_cnt, rsp_cnt, stim_q.size(), tmo_cnt);
    if (err_cnt != 0 || tmo_cnt != 0 || rsp_cnt != stim_q.size()) begin
      $display("TEST FAIL");
    end else begin
      $display("TEST PASS");
    end
    $finish;
  end

endmodule
